/* src/lcd_pkg.sv */
package lcd_pkg;

	// ----------------------------------------
	// line geometry
	// ----------------------------------------
	localparam int LINE_PIXELS = 160;                    // max pixels per line.
	localparam int PX_BITS     = 2;                      // 2-bit source pixel.
	localparam int BANK_COUNT  = 2;                      // ping-pong banks.
	localparam int ADDR_W      = $clog2(LINE_PIXELS);    // bank address.
	localparam int LEN_W       = $clog2(LINE_PIXELS + 1); // holds 0..LINE_PIXELS.
	localparam int BANK_SEL_W  = $clog2(BANK_COUNT);

	// gray codes for the four pixel values, one nibble each.
	localparam logic [3:0] GRAY0 = 4'd0;
	localparam logic [3:0] GRAY1 = 4'd2;
	localparam logic [3:0] GRAY2 = 4'd7;
	localparam logic [3:0] GRAY3 = 4'd15;

	// ----------------------------------------
	// controller commands
	// ----------------------------------------
	localparam logic [7:0] CMD_SYSTEM_RESET = 8'he2;
	localparam int         CLEAR_BYTES      = 12800;  // whole display RAM.
	localparam int         SEQ_CNT_W        = $clog2(CLEAR_BYTES);
	localparam int         INIT_COUNT       = 16;

	// mapping, line rate, loading, gray scale, bias, gain + value, partial,
	// ram addressing, enable, then scroll / page / column address pairs.
	localparam logic [7:0] INIT_CMDS [INIT_COUNT] = '{
		8'hc6, 8'ha1, 8'h2a, 8'hd2,
		8'hea, 8'h81, 8'h00, 8'h84,
		8'h8b, 8'haf, 8'h40, 8'h50,
		8'h60, 8'h70, 8'h00, 8'h13
	};

	localparam int FRAME_CMD_FIRST = 12;   // page lsb, resent each frame.

	typedef enum logic [2:0] {
		st_off,
		st_init_reset,
		st_clear,
		st_init_cmds,
		st_on,
		st_uninit
	} seq_state_t;

endpackage

/* src/line_capture.sv */
`timescale 1ns/10ps

module line_capture (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            n_hsync,
	input  logic                            p_hsync,
	input  logic                            n_vsync,
	input  logic                            p_vsync,
	input  logic                            n_latch,
	input  logic                            p_latch,
	input  logic                            n_pclk,
	input  logic                            p_pclk,
	input  logic [lcd_pkg::PX_BITS-1:0]     n_px,
	input  logic [lcd_pkg::PX_BITS-1:0]     p_px,
	output logic                            wr_en,
	output logic [lcd_pkg::ADDR_W-1:0]      wr_addr,
	output logic [lcd_pkg::PX_BITS-1:0]     wr_px,
	output logic [lcd_pkg::BANK_COUNT-1:0]  bank_wr_sel,
	output logic                            line_done,
	output logic [lcd_pkg::LEN_W-1:0]       line_len,
	output logic [lcd_pkg::BANK_SEL_W-1:0]  rd_bank,
	output logic                            frame_start,
	output logic                            in_sync
);
	import lcd_pkg::*;

	logic prev_hsync; // rising-half samples from last cycle.
	logic prev_latch;
	logic prev_pclk;

	logic                  rec_px;    // accepting pixels, set by pclk in hsync.
	logic [LEN_W-1:0]      wr_cnt;
	logic [BANK_SEL_W-1:0] fill_bank;

	// ----------------------------------------
	// fall detection on both halves
	// ----------------------------------------
	// p half: n sample high, p sample low within this cycle.
	// n half: last p sample high, n sample low.
	logic hs_fall_p, hs_fall_n, la_fall_p, la_fall_n, pc_fall_p, pc_fall_n;
	logic fall_p, fall_n, la_fall, new_line, frame_hit, store;

	assign hs_fall_p = n_hsync && !p_hsync;
	assign hs_fall_n = prev_hsync && !n_hsync;
	assign la_fall_p = n_latch && !p_latch;
	assign la_fall_n = prev_latch && !n_latch;
	assign pc_fall_p = n_pclk && !p_pclk;
	assign pc_fall_n = prev_pclk && !n_pclk;

	assign fall_p    = hs_fall_p || pc_fall_p || la_fall_p;
	assign fall_n    = hs_fall_n || pc_fall_n || la_fall_n;
	assign la_fall   = la_fall_p || la_fall_n;
	assign new_line  = (p_hsync && pc_fall_p) || (n_hsync && pc_fall_n);
	assign frame_hit = n_vsync && p_vsync && (hs_fall_p || hs_fall_n);
	assign store     = rec_px && (wr_cnt != LEN_W'(LINE_PIXELS)) && (fall_p || fall_n);

	always_ff @(posedge clk) begin
		prev_hsync <= p_hsync;
		prev_latch <= p_latch;
		prev_pclk  <= p_pclk;

		// write port, one cycle behind the edge.
		wr_en       <= store;
		wr_addr     <= ADDR_W'(wr_cnt);
		wr_px       <= fall_p ? p_px : n_px; // p half wins if both fell.
		bank_wr_sel <= BANK_COUNT'(1) << fill_bank;

		line_done   <= la_fall;
		frame_start <= frame_hit;

		if (store)
			wr_cnt <= wr_cnt + 1'b1;

		if (new_line) begin // pclk fall inside hsync restarts the line.
			wr_cnt <= '0;
			rec_px <= 1'b1;
		end

		if (la_fall) begin
			rd_bank  <= fill_bank;                  // finished line goes to reader.
			line_len <= wr_cnt + LEN_W'(store);     // latch pixel counts too.
			wr_cnt   <= '0;
			rec_px   <= 1'b0;                        // idle until next hsync.
			if (fill_bank == BANK_SEL_W'(BANK_COUNT - 1))
				fill_bank <= '0;
			else
				fill_bank <= fill_bank + 1'b1;
		end

		if (frame_hit)
			in_sync <= 1'b1;
		else if ((!n_vsync || !p_vsync) && (n_hsync || p_hsync || n_pclk || p_pclk))
			in_sync <= 1'b0; // lost sync.

		if (reset) begin
			wr_en       <= 1'b0;
			line_done   <= 1'b0;
			frame_start <= 1'b0;
			in_sync     <= 1'b0;
			rec_px      <= 1'b0;
			wr_cnt      <= '0;
			fill_bank   <= '0;
			rd_bank     <= BANK_SEL_W'(BANK_COUNT - 1);
		end
	end

endmodule

/* src/line_bank.sv */
`timescale 1ns/10ps

module line_bank (
	input  logic                        clk,
	input  logic                        wr_en,
	input  logic [lcd_pkg::ADDR_W-1:0]  wr_addr,
	input  logic [lcd_pkg::PX_BITS-1:0] wr_px,
	input  logic [lcd_pkg::ADDR_W-1:0]  rd_addr,
	output logic [lcd_pkg::PX_BITS-1:0] rd_px
);
	import lcd_pkg::*;

	// one line of 2-bit pixels.
	logic [PX_BITS-1:0] mem [LINE_PIXELS];

	// ----------------------------------------
	// write port and registered read
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_px;
	end

	always_ff @(posedge clk) begin
		rd_px <= mem[rd_addr]; // data one cycle after address.
	end

endmodule

/* src/pixel_packer.sv */
`timescale 1ns/10ps

module pixel_packer (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           line_done,
	input  logic [lcd_pkg::LEN_W-1:0]      line_len,
	input  logic [lcd_pkg::BANK_SEL_W-1:0] rd_bank,
	input  logic                           stream_en,
	input  logic [lcd_pkg::PX_BITS-1:0]    rd_px [lcd_pkg::BANK_COUNT],
	output logic [lcd_pkg::ADDR_W-1:0]     rd_addr,
	output logic                           px_write,
	output logic [7:0]                     px_byte
);
	import lcd_pkg::*;

	logic                  issuing;   // addresses still going out.
	logic [ADDR_W-1:0]     last_addr;
	logic [BANK_SEL_W-1:0] bank_sel;
	logic                  pend;      // rd_px valid this cycle.
	logic                  pend_odd;  // ...and belongs to an odd pixel.
	logic [3:0]            low_nib;
	logic [PX_BITS-1:0]    cur_px;
	logic                  start;

	function automatic logic [3:0] gray_of(input logic [PX_BITS-1:0] px);
		case (px)
			2'd0:    gray_of = GRAY0;
			2'd1:    gray_of = GRAY1;
			2'd2:    gray_of = GRAY2;
			default: gray_of = GRAY3;
		endcase
	endfunction

	assign cur_px = rd_px[bank_sel];
	// need at least one pair; an odd tail pixel is dropped.
	assign start  = line_done && stream_en && !issuing && (line_len[LEN_W-1:1] != '0);

	// ----------------------------------------
	// address walk
	// ----------------------------------------
	// rd_addr idles at 0, so pixel 0 is already being read on line_done.
	always_ff @(posedge clk) begin
		pend <= 1'b0;
		if (start) begin
			issuing   <= 1'b1;
			rd_addr   <= ADDR_W'(1);
			last_addr <= ADDR_W'({line_len[LEN_W-1:1], 1'b0} - 1'b1);
			bank_sel  <= rd_bank;
			pend      <= 1'b1;
			pend_odd  <= 1'b0;
		end else if (issuing) begin
			pend     <= 1'b1;
			pend_odd <= rd_addr[0];
			if (rd_addr == last_addr) begin
				issuing <= 1'b0;
				rd_addr <= '0;
			end else
				rd_addr <= rd_addr + 1'b1;
		end
		if (reset) begin
			issuing <= 1'b0;
			rd_addr <= '0;
			pend    <= 1'b0;
		end
	end

	// even pixel parks in low nibble, odd pixel closes the byte.
	always_ff @(posedge clk) begin
		px_write <= 1'b0;
		if (pend && !pend_odd)
			low_nib <= gray_of(cur_px);
		if (pend && pend_odd) begin
			px_write <= 1'b1;
			px_byte  <= {gray_of(cur_px), low_nib};
		end
		if (reset)
			px_write <= 1'b0;
	end

endmodule

/* src/lcd_sequencer.sv */
`timescale 1ns/10ps

module lcd_sequencer (
	input  logic       clk,
	input  logic       reset,
	input  logic       disp_on,
	input  logic       frame_start,
	input  logic       in_sync,
	input  logic       px_write,
	input  logic [7:0] px_byte,
	output logic       stream_en,
	output logic [7:0] lcd_data,
	output logic       lcd_write,
	output logic       lcd_cd
);
	import lcd_pkg::*;

	seq_state_t           state;
	logic [SEQ_CNT_W-1:0] cnt;  // clear byte count, or command index.
	logic                 gap;  // idle half of a two-cycle write slot.

	logic last_clear, last_cmd;

	assign last_clear = (cnt == SEQ_CNT_W'(CLEAR_BYTES - 1));
	assign last_cmd   = (cnt[3:0] == 4'(INIT_COUNT - 1));

	// ----------------------------------------
	// power, init and frame FSM
	// ----------------------------------------
	always_ff @(posedge clk) begin
		lcd_write <= 1'b0; // strobe, one cycle wide.

		case (state)
			st_off: begin
				stream_en <= 1'b0;
				gap       <= 1'b0;
				if (disp_on)
					state <= st_init_reset;
			end

			st_init_reset: begin // single system reset.
				lcd_write <= 1'b1;
				lcd_cd    <= 1'b0;
				lcd_data  <= CMD_SYSTEM_RESET;
				gap       <= 1'b1;
				cnt       <= '0;
				state     <= st_clear;
			end

			st_clear: begin
				if (gap)
					gap <= 1'b0;
				else begin
					lcd_write <= 1'b1;
					lcd_cd    <= 1'b1; // ram data, all zero.
					lcd_data  <= 8'h00;
					gap       <= 1'b1;
					if (last_clear) begin
						cnt   <= '0;
						state <= st_init_cmds;
					end else
						cnt <= cnt + 1'b1;
				end
			end

			// full table on power-up, tail of it on each frame.
			st_init_cmds: begin
				if (gap)
					gap <= 1'b0;
				else begin
					lcd_write <= 1'b1;
					lcd_cd    <= 1'b0;
					lcd_data  <= INIT_CMDS[cnt[3:0]];
					gap       <= 1'b1;
					if (last_cmd) begin
						stream_en <= 1'b1; // pixels may flow again.
						state     <= st_on;
					end else
						cnt <= cnt + 1'b1;
				end
			end

			st_on: begin
				if (!disp_on) begin
					stream_en <= 1'b0;
					state     <= st_uninit;
				end else if (frame_start) begin
					// back to the top-left corner.
					stream_en <= 1'b0;
					cnt       <= SEQ_CNT_W'(FRAME_CMD_FIRST);
					gap       <= 1'b0;
					state     <= st_init_cmds;
				end else if (px_write && in_sync) begin
					lcd_write <= 1'b1;
					lcd_cd    <= 1'b1;
					lcd_data  <= px_byte;
				end
			end

			st_uninit: begin
				lcd_write <= 1'b1;
				lcd_cd    <= 1'b0;
				lcd_data  <= CMD_SYSTEM_RESET; // leave panel in reset.
				stream_en <= 1'b0;
				state     <= st_off;
			end

			default: state <= st_off;
		endcase

		if (reset) begin
			state     <= st_off;
			cnt       <= '0;
			gap       <= 1'b0;
			stream_en <= 1'b0;
			lcd_write <= 1'b0;
		end
	end

endmodule

/* src/lcd_bridge_top.sv */
`timescale 1ns/10ps

module lcd_bridge_top (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        disp_on,
	input  logic                        n_hsync,
	input  logic                        p_hsync,
	input  logic                        n_vsync,
	input  logic                        p_vsync,
	input  logic                        n_latch,
	input  logic                        p_latch,
	input  logic                        n_pclk,
	input  logic                        p_pclk,
	input  logic [lcd_pkg::PX_BITS-1:0] n_px,
	input  logic [lcd_pkg::PX_BITS-1:0] p_px,
	output logic [7:0]                  lcd_data,
	output logic                        lcd_write,
	output logic                        lcd_cd,
	output logic                        lcd_read,
	output logic                        lcd_cs,
	output logic                        lcd_vled
);
	import lcd_pkg::*;

	logic                  wr_en;
	logic [ADDR_W-1:0]     wr_addr;
	logic [PX_BITS-1:0]    wr_px;
	logic [BANK_COUNT-1:0] bank_wr_sel;
	logic                  line_done;
	logic [LEN_W-1:0]      line_len;
	logic [BANK_SEL_W-1:0] rd_bank;
	logic                  frame_start;
	logic                  in_sync;
	logic [ADDR_W-1:0]     rd_addr;
	logic [PX_BITS-1:0]    bank_rd_px [BANK_COUNT];
	logic                  px_write;
	logic [7:0]            px_byte;
	logic                  stream_en;

	assign lcd_read = 1'b0; // write-only bus.
	assign lcd_cs   = 1'b1;
	assign lcd_vled = disp_on;

	line_capture line_capture_i (
		.clk, .reset,
		.n_hsync, .p_hsync, .n_vsync, .p_vsync,
		.n_latch, .p_latch, .n_pclk, .p_pclk,
		.n_px, .p_px,
		.wr_en, .wr_addr, .wr_px, .bank_wr_sel,
		.line_done, .line_len, .rd_bank,
		.frame_start, .in_sync
	);

	// ----------------------------------------
	// ping-pong line banks
	// ----------------------------------------
	for (genvar g = 0; g < BANK_COUNT; g++) begin : gen_bank
		line_bank line_bank_i (
			.clk,
			.wr_en   (wr_en && bank_wr_sel[g]), // only the fill bank writes.
			.wr_addr,
			.wr_px,
			.rd_addr,
			.rd_px   (bank_rd_px[g])
		);
	end

	pixel_packer pixel_packer_i (
		.clk, .reset,
		.line_done, .line_len, .rd_bank, .stream_en,
		.rd_px (bank_rd_px),
		.rd_addr, .px_write, .px_byte
	);

	lcd_sequencer lcd_sequencer_i (
		.clk, .reset, .disp_on,
		.frame_start, .in_sync, .px_write, .px_byte,
		.stream_en, .lcd_data, .lcd_write, .lcd_cd
	);

endmodule

/* testbench/lcd_bridge_monitor.sv */
`timescale 1ns/10ps

module lcd_bridge_monitor (
	input logic       clk,
	input logic       reset,
	input logic       disp_on,
	input logic [7:0] lcd_data,
	input logic       lcd_write,
	input logic       lcd_cd,
	input logic       lcd_read,
	input logic       lcd_cs,
	input logic       lcd_vled
);

	logic [8:0] exp_q [$]; // {cd, data} in bus order.

	int writes       = 0;
	int data_errors  = 0;
	int cd_errors    = 0;
	int extra_writes = 0;
	int pin_errors   = 0;
	int leftover     = 0;

	task automatic expect_write(input logic cd, input logic [7:0] data);
		exp_q.push_back({cd, data});
	endtask

	function automatic int pending();
		return exp_q.size();
	endfunction

	// ----------------------------------------
	// bus sampling, mid-cycle
	// ----------------------------------------
	always @(negedge clk) begin : sample
		logic [8:0] exp;

		if (!reset) begin
			if (lcd_cs !== 1'b1) begin // chip select tied high.
				pin_errors++;
				$display("error lcd_cs: got %h, expected %h", lcd_cs, 1'b1);
			end
			if (lcd_read !== 1'b0) begin
				pin_errors++;
				$display("error lcd_read: got %h, expected %h", lcd_read, 1'b0);
			end
			if (lcd_vled !== disp_on) begin // backlight follows disp_on.
				pin_errors++;
				$display("error lcd_vled: got %h, expected %h", lcd_vled, disp_on);
			end
			if (lcd_write !== 1'b0 && lcd_write !== 1'b1) begin
				pin_errors++;
				$display("error lcd_write: got %h, expected a known level", lcd_write);
			end

			if (lcd_write === 1'b1) begin
				writes++;
				if (exp_q.size() == 0) begin
					extra_writes++;
					$display("unexpected LCD write at %0t with nothing expected, data %h cd %h",
						$time, lcd_data, lcd_cd);
				end else begin
					exp = exp_q.pop_front();
					if (lcd_data !== exp[7:0]) begin
						data_errors++;
						$display("error lcd_data: got %h, expected %h, write %0d",
							lcd_data, exp[7:0], writes);
					end
					if (lcd_cd !== exp[8]) begin
						cd_errors++;
						$display("error lcd_cd: got %h, expected %h, write %0d",
							lcd_cd, exp[8], writes);
					end
				end
			end
		end
	end

	// whatever is still queued never reached the bus.
	task automatic check_leftover();
		leftover = exp_q.size();
		if (leftover != 0)
			$display("%0d expected LCD writes never arrived, first missing cd %h data %h",
				leftover, exp_q[0][8], exp_q[0][7:0]);
	endtask

endmodule

/* testbench/lcd_bridge_tb.sv */
`timescale 1ns/10ps

module lcd_bridge_tb;

	localparam int CLEAR_BYTES = 12800;
	localparam int INIT_COUNT  = 16;
	localparam int FRAME_FIRST = 12;   // page/column address commands.
	localparam int LINE_COUNT  = 10;
	localparam int WAIT_LIMIT  = 1000; // cycles per line wait.

	logic       clk;
	logic       reset;
	logic       disp_on;
	logic       n_hsync, p_hsync, n_vsync, p_vsync;
	logic       n_latch, p_latch, n_pclk, p_pclk;
	logic [1:0] n_px, p_px;
	logic [7:0] lcd_data;
	logic       lcd_write, lcd_cd, lcd_read, lcd_cs, lcd_vled;

	logic [31:0] lfsr     = 32'h6bfb_804b;
	int          timeouts = 0;

	// controller init commands in send order.
	logic [7:0] init_table [INIT_COUNT] = '{
		8'hc6, 8'ha1, 8'h2a, 8'hd2, 8'hea, 8'h81, 8'h00, 8'h84,
		8'h8b, 8'haf, 8'h40, 8'h50, 8'h60, 8'h70, 8'h00, 8'h13
	};

	lcd_bridge_top lcd_bridge_top_i (
		.clk, .reset, .disp_on,
		.n_hsync, .p_hsync, .n_vsync, .p_vsync,
		.n_latch, .p_latch, .n_pclk, .p_pclk,
		.n_px, .p_px,
		.lcd_data, .lcd_write, .lcd_cd, .lcd_read, .lcd_cs, .lcd_vled
	);

	lcd_bridge_monitor monitor_i (
		.clk, .reset, .disp_on,
		.lcd_data, .lcd_write, .lcd_cd, .lcd_read, .lcd_cs, .lcd_vled
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ----------------------------------------
	// helpers
	// ----------------------------------------
	// galois lfsr with one shift per bit taken.
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r    = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha300_0000) : (lfsr >> 1);
		end
		return r;
	endfunction

	function automatic logic [3:0] gray_code(input logic [1:0] v);
		case (v)
			2'd0:    return 4'h0;
			2'd1:    return 4'h2;
			2'd2:    return 4'h7;
			default: return 4'hf;
		endcase
	endfunction

	// one clk of source pins with each pair as {n, p}.
	task automatic drive(input logic [1:0] hs, vs, la, pc);
		{n_hsync, p_hsync} = hs;
		{n_vsync, p_vsync} = vs;
		{n_latch, p_latch} = la;
		{n_pclk, p_pclk}   = pc;
		@(posedge clk);
		#10;
		n_px = 2'b00; // pixel only valid with its fall.
		p_px = 2'b00;
	endtask

	// vsync stays up and everything else low.
	task automatic drive_idle();
		drive(2'b00, 2'b11, 2'b00, 2'b00);
	endtask

	// falling half carries the pixel and the other half its inverse.
	task automatic set_px(input bit half, input logic [1:0] v);
		n_px = half ? ~v : v;
		p_px = half ? v : ~v;
	endtask

	task automatic end_run();
		int total;
		monitor_i.check_leftover();
		total = monitor_i.data_errors + monitor_i.cd_errors + monitor_i.extra_writes
			+ monitor_i.pin_errors + monitor_i.leftover + timeouts;
		$display("writes %0d, errors data %0d cd %0d extra %0d pin %0d missing %0d timeout %0d",
			monitor_i.writes, monitor_i.data_errors, monitor_i.cd_errors,
			monitor_i.extra_writes, monitor_i.pin_errors, monitor_i.leftover, timeouts);
		if (total == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	endtask

	// idle until at most level writes are still expected.
	task automatic wait_queue(input int level, input int limit, input string what);
		int waited;
		waited = 0;
		while (monitor_i.pending() > level && waited < limit) begin
			drive_idle();
			waited++;
		end
		if (monitor_i.pending() > level) begin
			$display("timeout while waiting for %s after %0d cycles", what, limit);
			timeouts++;
			end_run();
		end
	endtask

	// ----------------------------------------
	// one source line
	// ----------------------------------------
	// hsync fall = pixel 0, pclk falls = middle pixels, latch fall = last.
	// vsync drops only where hsync and pclk are low, so in_sync holds.
	task automatic send_line(input bit frame, input bit live);
		logic [1:0] px [160];
		int         len;
		int         gap;
		bit         half;

		len = 20 + 2 * int'(random_bits(7) % 71);
		for (int i = 0; i < len; i++)
			px[i] = 2'(random_bits(2));

		if (frame)
			wait_queue(0, WAIT_LIMIT, "previous line before frame start");
		if (live) begin
			if (frame)
				for (int k = FRAME_FIRST; k < INIT_COUNT; k++)
					monitor_i.expect_write(1'b0, init_table[k]);
			for (int k = 0; k < len / 2; k++)
				monitor_i.expect_write(1'b1, {gray_code(px[2*k+1]), gray_code(px[2*k])});
		end

		drive(2'b11, 2'b11, 2'b00, 2'b11); // hsync and pclk up.
		drive(2'b11, 2'b11, 2'b00, 2'b00); // pclk falls inside hsync.

		half = frame ? (random_bits(1) != 0) : 1'b0; // non-frame falls on n half.
		set_px(half, px[0]);
		drive(half ? 2'b10 : 2'b00, frame ? 2'b11 : 2'b00, 2'b00, 2'b00);

		for (int i = 1; i < len - 1; i++) begin
			gap = 4 + int'(random_bits(2));
			for (int j = 0; j < gap - 2; j++)
				drive_idle();
			drive(2'b00, 2'b11, 2'b00, 2'b11);
			half = (random_bits(1) != 0);
			set_px(half, px[i]);
			drive(2'b00, 2'b11, 2'b00, half ? 2'b10 : 2'b00);
		end
		drive_idle();

		// reader must have drained the other bank first.
		wait_queue(live ? len / 2 : 0, WAIT_LIMIT, "previous line before latch");
		drive(2'b00, 2'b11, 2'b11, 2'b00);
		half = (random_bits(1) != 0);
		set_px(half, px[len-1]);
		drive(2'b00, 2'b11, half ? 2'b10 : 2'b00, 2'b00);
		drive_idle();
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin
		reset   = 1'b1;
		disp_on = 1'b0;
		n_hsync = 1'b0;
		p_hsync = 1'b0;
		n_vsync = 1'b1;
		p_vsync = 1'b1;
		n_latch = 1'b0;
		p_latch = 1'b0;
		n_pclk  = 1'b0;
		p_pclk  = 1'b0;
		n_px    = 2'b00;
		p_px    = 2'b00;
		repeat (3) @(posedge clk);
		#10;
		reset = 1'b0;
		repeat (4) drive_idle();

		// power-up sends reset, ram clear and the full init table.
		monitor_i.expect_write(1'b0, 8'he2);
		for (int i = 0; i < CLEAR_BYTES; i++)
			monitor_i.expect_write(1'b1, 8'h00);
		for (int i = 0; i < INIT_COUNT; i++)
			monitor_i.expect_write(1'b0, init_table[i]);
		disp_on = 1'b1;
		wait_queue(0, 2 * CLEAR_BYTES + 200, "power-up sequence");

		// first line opens a frame, which sets in_sync.
		for (int i = 0; i < LINE_COUNT; i++)
			send_line(i % 4 == 0, 1'b1);
		wait_queue(0, WAIT_LIMIT, "last line output");

		// power-down and then a line that must not reach the bus.
		monitor_i.expect_write(1'b0, 8'he2);
		disp_on = 1'b0;
		wait_queue(0, 100, "power-down reset command");
		send_line(1'b1, 1'b0);
		repeat (50) drive_idle();
		end_run();
	end

endmodule

/* sources.f */
src/lcd_pkg.sv
src/line_capture.sv
src/line_bank.sv
src/pixel_packer.sv
src/lcd_sequencer.sv
src/lcd_bridge_top.sv
testbench/lcd_bridge_monitor.sv
testbench/lcd_bridge_tb.sv
